// File: src/ethRxPkg.sv
/* Receive states, datapath flags, frame-end record, APB register offsets
   and frame limits shared by the MII receive blocks */
package ethRxPkg;

        //////////////////////////////////////////////////////////////////////
        // Frame limits
        //////////////////////////////////////////////////////////////////////

        // Idle nibbles needed before an SFD is accepted
        localparam int IfgNibbles    = 24;
        // Longest frame in bytes, small enough to reach in simulation
        localparam int MaxFrameBytes = 64;
        localparam int ByteCntWidth  = $clog2(MaxFrameBytes + 1);
        localparam int IfgCntWidth   = $clog2(IfgNibbles + 1);

        // CRC-32 generator and the remainder left by a good frame plus FCS
        localparam logic [31:0] CrcPoly    = 32'h04C11DB7;
        localparam logic [31:0] CrcResidue = 32'hC704DD7B;

        //////////////////////////////////////////////////////////////////////
        // APB register map
        //////////////////////////////////////////////////////////////////////

        localparam int AddrWidth = 4;
        localparam logic [AddrWidth-1:0] RegGoodFrames = 4'h0;
        localparam logic [AddrWidth-1:0] RegCrcErrors  = 4'h4;
        localparam logic [AddrWidth-1:0] RegDropped    = 4'h8;
        localparam logic [AddrWidth-1:0] RegLastLength = 4'hC;

        // Receive state, Data0 expects the low nibble and Data1 the high one
        typedef enum logic [2:0] {Idle, Preamble, Sfd, Data0, Data1, Drop} rxState_e;

        // Compare and counter flags from datapath to state machine
        typedef struct packed {
                logic nibbleEq5;
                logic nibbleEqD;
                logic ifgEq24;
                logic byteCntMax;
        } rxFlags_t;

        // One finished or dropped frame
        typedef struct packed {
                logic        valid;
                logic        dropped;
                logic        crcOk;
                logic [15:0] length;
        } frameEnd_t;

endpackage

// File: src/ethRxStateMachine.sv
/* Receive FSM tracking idle, preamble, SFD, data nibbles and drop */
`timescale 1ns/10ps

module ethRxStateMachine
(
        input  logic               MRxClk,
        input  logic               Reset,
        input  logic               MRxDV,
        input  logic               Transmitting,
        input  ethRxPkg::rxFlags_t flags,
        output ethRxPkg::rxState_e state
);
        import ethRxPkg::*;

        rxState_e nextState;

        //////////////////////////////////////////////////////////////////////
        // Next state
        //////////////////////////////////////////////////////////////////////

        always_comb
        begin
                nextState = state;
                // Loss of data-valid ends whatever is in progress
                if (!MRxDV)
                begin
                        nextState = Idle;
                end
                else
                begin
                        case (state)
                                Idle:
                                begin
                                        // Own transmission in progress, ignore the frame
                                        if (Transmitting)
                                                nextState = Drop;
                                        else if (flags.nibbleEq5)
                                                nextState = Sfd;
                                        else
                                                nextState = Preamble;
                                end
                                Preamble:
                                begin
                                        if (flags.nibbleEq5)
                                                nextState = Sfd;
                                end
                                Sfd:
                                begin
                                        // SFD too close to the previous frame is dropped
                                        if (flags.nibbleEqD)
                                                nextState = flags.ifgEq24 ? Data0 : Drop;
                                end
                                Data0:
                                begin
                                        if (flags.byteCntMax)
                                                nextState = Drop;
                                        else
                                                nextState = Data1;
                                end
                                Data1:
                                begin
                                        nextState = Data0;
                                end
                                Drop:
                                begin
                                        // Wait here for data-valid to fall
                                        nextState = Drop;
                                end
                                default:
                                begin
                                        nextState = Drop;
                                end
                        endcase
                end
        end

        // State register, reset parks in Drop until the line goes quiet
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        state <= Drop;
                else
                        state <= nextState;
        end

        //////////////////////////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////////////////////////

        assert property (@(posedge MRxClk) disable iff (Reset)
                !$isunknown(state) && (state inside {Idle, Preamble, Sfd, Data0, Data1, Drop}));

        // Data-valid low always returns to Idle one edge later
        assert property (@(posedge MRxClk) disable iff (Reset)
                !MRxDV |=> state == Idle);

        // A dropped frame stays dropped for as long as it lasts
        assert property (@(posedge MRxClk) disable iff (Reset)
                (state == Drop) && MRxDV |=> state == Drop);

endmodule

// File: src/ethRxDatapath.sv
/* Nibble compares, byte assembly, byte counter and inter-frame gap counter */
`timescale 1ns/10ps

module ethRxDatapath
(
        input  logic               MRxClk,
        input  logic               Reset,
        input  logic [3:0]         MRxD,
        input  ethRxPkg::rxState_e state,
        output ethRxPkg::rxFlags_t flags,
        output logic [15:0]        byteCount,
        output logic [7:0]         rxByte,
        output logic               rxByteValid
);
        import ethRxPkg::*;

        logic [3:0]              lowNibble;
        logic [ByteCntWidth-1:0] byteCnt;
        logic [IfgCntWidth-1:0]  ifgCnt;
        logic                    inData;

        assign inData = (state == Data0) || (state == Data1);

        // Flags for the FSM, combinational from the nibble and counters
        assign flags.nibbleEq5  = (MRxD == 4'h5);
        assign flags.nibbleEqD  = (MRxD == 4'hD);
        assign flags.ifgEq24    = (ifgCnt == IfgCntWidth'(IfgNibbles));
        assign flags.byteCntMax = (byteCnt == ByteCntWidth'(MaxFrameBytes));

        assign byteCount = 16'(byteCnt);

        //////////////////////////////////////////////////////////////////////
        // Byte assembly
        //////////////////////////////////////////////////////////////////////

        // Low nibble arrives first on MII
        always_ff @(posedge MRxClk)
        begin
                if (state == Data0)
                        lowNibble <= MRxD;
                if (state == Data1)
                        rxByte <= {MRxD, lowNibble};
        end

        // One-cycle strobe per completed byte
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        rxByteValid <= 1'b0;
                else
                        rxByteValid <= (state == Data1);
        end

        //////////////////////////////////////////////////////////////////////
        // Counters
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        byteCnt <= '0;
                        ifgCnt  <= '0;
                end
                else
                begin
                        // New frame restarts the byte count
                        if (state == Sfd)
                                byteCnt <= '0;
                        else if (state == Data1)
                                byteCnt <= byteCnt + 1'b1;

                        // Gap counts idle cycles, saturates at the minimum gap
                        if (inData)
                                ifgCnt <= '0;
                        else if (ifgCnt != IfgCntWidth'(IfgNibbles))
                                ifgCnt <= ifgCnt + 1'b1;
                end
        end

        // Length limit in the FSM keeps the count in range
        assert property (@(posedge MRxClk) disable iff (Reset)
                byteCnt <= ByteCntWidth'(MaxFrameBytes));

endmodule

// File: src/ethRxCrc.sv
/* Nibble-wide CRC-32 over the data phase with residue check */
`timescale 1ns/10ps

module ethRxCrc
(
        input  logic               MRxClk,
        input  logic               Reset,
        input  logic [3:0]         MRxD,
        input  ethRxPkg::rxState_e state,
        output logic               crcOk
);
        import ethRxPkg::*;

        logic [31:0] crc;
        logic [3:0]  nibbleQ;
        logic        foldQ;

        // Fold four data bits, least significant first
        function automatic logic [31:0] crcNibble(input logic [31:0] crcIn,
                                                  input logic [3:0]  data);
                logic [31:0] c;
                logic        fb;
                c = crcIn;
                for (int i = 0; i < 4; i++)
                begin
                        fb = c[31] ^ data[i];
                        c  = {c[30:0], 1'b0};
                        if (fb)
                                c = c ^ CrcPoly;
                end
                return c;
        endfunction

        // Data nibbles wait one cycle; the FSM state then tells whether
        // MRxDV was still high when it was sampled
        always_ff @(posedge MRxClk)
        begin
                nibbleQ <= MRxD;
        end

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        crc   <= '1;
                        foldQ <= 1'b0;
                end
                else
                begin
                        foldQ <= (state == Data0) || (state == Data1);
                        // Preload while waiting for the SFD
                        if (state == Sfd)
                                crc <= '1;
                        else if (foldQ && (state != Idle))
                                crc <= crcNibble(crc, nibbleQ);
                end
        end

        // Good frame plus FCS leaves the fixed residue
        assign crcOk = (crc == CrcResidue);

endmodule

// File: src/ethRxStatusRegs.sv
/* Frame-end detection, frame statistics counters and APB read port */
`timescale 1ns/10ps

module ethRxStatusRegs
(
        input  logic                             MRxClk,
        input  logic                             Reset,
        input  ethRxPkg::rxState_e               state,
        input  logic                             crcOk,
        input  logic [15:0]                      byteCount,
        output logic                             rxFrameEnd,
        input  logic                             PSEL,
        input  logic                             PENABLE,
        input  logic                             PWRITE,
        input  logic [ethRxPkg::AddrWidth-1:0]   PADDR,
        output logic [31:0]                      PRDATA,
        output logic                             PSLVERR
);
        import ethRxPkg::*;

        rxState_e    prevState;
        frameEnd_t   endRec;
        logic [31:0] goodFrames;
        logic [31:0] crcErrors;
        logic [31:0] droppedFrames;
        logic [15:0] lastLength;

        //////////////////////////////////////////////////////////////////////
        // Frame end and drop detection
        //////////////////////////////////////////////////////////////////////

        // Data phase ended because MRxDV fell
        assign endRec.valid   = ((prevState == Data0) || (prevState == Data1))
                                && (state == Idle);
        // Fresh entry into Drop
        assign endRec.dropped = (state == Drop) && (prevState != Drop);
        assign endRec.crcOk   = crcOk;
        assign endRec.length  = byteCount;

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        prevState     <= Drop;
                        rxFrameEnd    <= 1'b0;
                        goodFrames    <= '0;
                        crcErrors     <= '0;
                        droppedFrames <= '0;
                        lastLength    <= '0;
                end
                else
                begin
                        prevState  <= state;
                        rxFrameEnd <= endRec.valid;
                        if (endRec.valid)
                        begin
                                lastLength <= endRec.length;
                                if (endRec.crcOk)
                                        goodFrames <= goodFrames + 1'b1;
                                else
                                        crcErrors <= crcErrors + 1'b1;
                        end
                        if (endRec.dropped)
                                droppedFrames <= droppedFrames + 1'b1;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // APB read port, zero wait states
        //////////////////////////////////////////////////////////////////////

        always_comb
        begin
                PRDATA  = '0;
                PSLVERR = 1'b0;
                if (PSEL && PENABLE)
                begin
                        // Registers are read-only
                        if (PWRITE)
                        begin
                                PSLVERR = 1'b1;
                        end
                        else
                        begin
                                case (PADDR)
                                        RegGoodFrames: PRDATA = goodFrames;
                                        RegCrcErrors:  PRDATA = crcErrors;
                                        RegDropped:    PRDATA = droppedFrames;
                                        RegLastLength: PRDATA = {16'h0, lastLength};
                                        default:       PSLVERR = 1'b1;
                                endcase
                        end
                end
        end

        // Access phase must follow a setup phase with PSEL held
        assert property (@(posedge MRxClk) disable iff (Reset)
                PENABLE |-> PSEL);

endmodule

// File: src/ethRxMac.sv
/* Receive MAC front end connecting MII, host byte stream and APB statistics */
`timescale 1ns/10ps

module ethRxMac
(
        input  logic                           MRxClk,
        input  logic                           Reset,
        input  logic                           MRxDV,
        input  logic [3:0]                     MRxD,
        input  logic                           Transmitting,
        output logic [7:0]                     rxByte,
        output logic                           rxByteValid,
        output logic                           rxFrameEnd,
        input  logic                           PSEL,
        input  logic                           PENABLE,
        input  logic                           PWRITE,
        input  logic [ethRxPkg::AddrWidth-1:0] PADDR,
        output logic [31:0]                    PRDATA,
        output logic                           PSLVERR
);
        import ethRxPkg::*;

        rxFlags_t    flags;
        rxState_e    state;
        logic        crcOk;
        logic [15:0] byteCount;

        // FSM fed by datapath flags
        ethRxStateMachine stateMachine (.MRxClk, .Reset, .MRxDV, .Transmitting,
                                        .flags, .state);

        ethRxDatapath datapath (.MRxClk, .Reset, .MRxD, .state, .flags, .byteCount,
                                .rxByte, .rxByteValid);

        ethRxCrc crcCheck (.MRxClk, .Reset, .MRxD, .state, .crcOk);

        // Statistics and host register access
        ethRxStatusRegs statusRegs (.MRxClk, .Reset, .state, .crcOk, .byteCount,
                                    .rxFrameEnd, .PSEL, .PENABLE, .PWRITE, .PADDR,
                                    .PRDATA, .PSLVERR);

endmodule

// File: tests/ethRxMacTb.sv
/* Testbench for the MII receive MAC with frame and APB stimulus, CRC-32 model,
   byte scoreboard, statistics model, assertions and timeout */
`timescale 1ns/10ps

module ethRxMacTb;
        import ethRxPkg::*;

        // The whole sequence runs in under 1000 cycles
        localparam int TimeoutCycles = 4000;

        logic                 MRxClk = 1'b0;
        logic                 Reset;
        logic                 MRxDV;
        logic [3:0]           MRxD;
        logic                 Transmitting;
        logic [7:0]           rxByte;
        logic                 rxByteValid;
        logic                 rxFrameEnd;
        logic                 PSEL;
        logic                 PENABLE;
        logic                 PWRITE;
        logic [AddrWidth-1:0] PADDR;
        logic [31:0]          PRDATA;
        logic                 PSLVERR;

        // Scoreboard and statistics model
        logic [7:0]  expQ [$];
        int          pendingEnds = 0;
        int          goodCount = 0;
        int          crcErrCount = 0;
        int          dropCount = 0;
        int          lastLength = 0;
        logic        quiet = 1'b0;
        logic        expErr = 1'b0;
        logic [31:0] expData = '0;
        int          idleRun = 0;
        int          cycleCount = 0;

        ethRxMac u_ethRxMac (.*);

        always #10 MRxClk = ~MRxClk;

        task automatic reportFailure(input string line);
                $display("%s", line);
                $display("Simulation finished: FAIL");
                $fatal(1);
        endtask

        //////////////////////////////////////////////////////////////////////
        // Monitors
        //////////////////////////////////////////////////////////////////////

        // Quiet cycles seen by the DUT since data-valid was last high
        always @(posedge MRxClk)
        begin
                idleRun <= MRxDV ? 0 : idleRun + 1;
        end

        always @(posedge MRxClk)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount == TimeoutCycles)
                        reportFailure("Timeout: the run did not finish within the cycle limit");
        end

        // Each delivered byte must match the next expected wire byte
        always @(posedge MRxClk)
        begin
                if (!Reset && rxByteValid)
                begin
                        assert (expQ.size() > 0)
                                else reportFailure("A byte arrived while none was expected");
                        assert (rxByte == expQ[0])
                                else reportFailure($sformatf("FAILED rxByte: got %h, expected %h",
                                                             rxByte, expQ[0]));
                        void'(expQ.pop_front());
                end
                if (!Reset && rxFrameEnd)
                begin
                        assert (pendingEnds > 0)
                                else reportFailure("Frame end pulse without a delivered frame");
                        assert (expQ.size() == 0)
                                else reportFailure("Frame ended before all its bytes arrived");
                        pendingEnds--;
                end
        end

        // Dropped frames stay invisible to the host
        assert property (@(posedge MRxClk) disable iff (Reset)
                quiet |-> !rxByteValid && !rxFrameEnd)
                else reportFailure("Host output seen during a dropped frame");

        assert property (@(posedge MRxClk) disable iff (Reset)
                PSEL && PENABLE |-> PSLVERR == expErr)
                else reportFailure($sformatf("FAILED PSLVERR: got %h, expected %h",
                                             $sampled(PSLVERR), $sampled(expErr)));

        assert property (@(posedge MRxClk) disable iff (Reset)
                PSEL && PENABLE && !PWRITE && !expErr |-> PRDATA == expData)
                else reportFailure($sformatf("FAILED PRDATA at %h: got %h, expected %h",
                                             $sampled(PADDR), $sampled(PRDATA),
                                             $sampled(expData)));

        //////////////////////////////////////////////////////////////////////
        // Models and stimulus
        //////////////////////////////////////////////////////////////////////

        // Reflected CRC-32, one byte at a time
        function automatic logic [31:0] crcByte(input logic [31:0] crc, input logic [7:0] b);
                logic [31:0] c;
                c = crc ^ {24'h0, b};
                for (int i = 0; i < 8; i++)
                        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
                return c;
        endfunction

        function automatic logic [31:0] regModel(input logic [AddrWidth-1:0] addr);
                case (addr)
                        RegGoodFrames: return 32'(goodCount);
                        RegCrcErrors:  return 32'(crcErrCount);
                        RegDropped:    return 32'(dropCount);
                        RegLastLength: return 32'(lastLength);
                        default:       return 32'h0;
                endcase
        endfunction

        task automatic driveNibble(input logic [3:0] n);
                @(posedge MRxClk);
                MRxDV <= 1'b1;
                MRxD  <= n;
        endtask

        task automatic gap(input int cycles);
                repeat (cycles)
                begin
                        @(posedge MRxClk);
                        MRxDV <= 1'b0;
                        MRxD  <= 4'h0;
                end
        endtask

        task automatic sendFrame(input int payloadLen, input int preLen, input bit corrupt);
                logic [7:0]  frameBytes [$];
                logic [31:0] crc;
                int          idx;
                bit          early;
                crc = 32'hFFFFFFFF;
                for (int i = 0; i < payloadLen; i++)
                begin
                        frameBytes.push_back(8'($urandom));
                        crc = crcByte(crc, frameBytes[i]);
                end
                // FCS goes out complemented, low byte first
                crc = ~crc;
                for (int i = 0; i < 4; i++)
                        frameBytes.push_back(crc[8*i +: 8]);
                if (corrupt)
                begin
                        idx = $urandom % payloadLen;
                        frameBytes[idx] = frameBytes[idx] ^ (8'h1 << ($urandom % 8));
                end
                // Gap count covers quiet cycles so far, one more, and the preamble
                early = Transmitting || (idleRun + preLen + 1 < IfgNibbles);
                quiet <= early;
                if (early)
                        dropCount++;
                else
                begin
                        for (int i = 0; i < frameBytes.size() && i < MaxFrameBytes; i++)
                                expQ.push_back(frameBytes[i]);
                        if (frameBytes.size() > MaxFrameBytes)
                                dropCount++;
                        else
                        begin
                                pendingEnds++;
                                lastLength = frameBytes.size();
                                if (corrupt)
                                        crcErrCount++;
                                else
                                        goodCount++;
                        end
                end
                repeat (preLen) driveNibble(4'h5);
                driveNibble(4'hD);
                foreach (frameBytes[i])
                begin
                        driveNibble(frameBytes[i][3:0]);
                        driveNibble(frameBytes[i][7:4]);
                end
        endtask

        // Setup cycle, then access cycle where the response is checked
        task automatic apbRead(input logic [AddrWidth-1:0] addr, input logic err);
                @(posedge MRxClk);
                PSEL    <= 1'b1;
                PWRITE  <= 1'b0;
                PADDR   <= addr;
                expErr  <= err;
                expData <= regModel(addr);
                @(posedge MRxClk);
                PENABLE <= 1'b1;
                @(posedge MRxClk);
                PSEL    <= 1'b0;
                PENABLE <= 1'b0;
        endtask

        task automatic apbWrite(input logic [AddrWidth-1:0] addr);
                @(posedge MRxClk);
                PSEL   <= 1'b1;
                PWRITE <= 1'b1;
                PADDR  <= addr;
                expErr <= 1'b1;
                @(posedge MRxClk);
                PENABLE <= 1'b1;
                @(posedge MRxClk);
                PSEL    <= 1'b0;
                PENABLE <= 1'b0;
                PWRITE  <= 1'b0;
        endtask

        task automatic checkStats();
                assert (expQ.size() == 0)
                        else reportFailure("Bytes of a delivered frame never arrived");
                assert (pendingEnds == 0)
                        else reportFailure("An expected frame end pulse never arrived");
                apbRead(RegGoodFrames, 1'b0);
                apbRead(RegCrcErrors, 1'b0);
                apbRead(RegDropped, 1'b0);
                apbRead(RegLastLength, 1'b0);
        endtask

        //////////////////////////////////////////////////////////////////////
        // Test sequence
        //////////////////////////////////////////////////////////////////////

        initial
        begin
                void'($urandom(32'hd215));
                Reset = 1'b1;
                MRxDV = 1'b0;
                MRxD = 4'h0;
                Transmitting = 1'b0;
                PSEL = 1'b0;
                PENABLE = 1'b0;
                PWRITE = 1'b0;
                PADDR = '0;
                repeat (10) @(posedge MRxClk);
                Reset <= 1'b0;
                gap(30);
                // Good frame, then one with a flipped bit
                sendFrame(8 + $urandom % 24, 15, 1'b0);
                gap(30);
                checkStats();
                sendFrame(30, 15, 1'b1);
                gap(30);
                checkStats();
                // Frame arriving during own transmission
                Transmitting <= 1'b1;
                gap(2);
                sendFrame(12, 15, 1'b0);
                Transmitting <= 1'b0;
                gap(30);
                checkStats();
                // SFD too soon after the previous data phase
                sendFrame(16, 7, 1'b0);
                gap(4);
                sendFrame(10, 3, 1'b0);
                gap(30);
                checkStats();
                // Over-length frame is cut at the byte limit
                sendFrame(70, 15, 1'b0);
                gap(30);
                checkStats();
                // Bus errors leave every register untouched
                apbWrite(RegGoodFrames);
                apbWrite(RegDropped);
                apbRead(4'h2, 1'b1);
                apbRead(4'h7, 1'b1);
                checkStats();
                sendFrame(8 + $urandom % 24, 15, 1'b0);
                gap(30);
                checkStats();
                $display("Simulation finished: PASS");
                $finish;
        end

endmodule

// File: files.f
src/ethRxPkg.sv
src/ethRxStateMachine.sv
src/ethRxDatapath.sv
src/ethRxCrc.sv
src/ethRxStatusRegs.sv
src/ethRxMac.sv
tests/ethRxMacTb.sv
